/* src/icache_refill_macros.svh */
// Instruction cache refill sizes
`ifndef ICACHE_REFILL_MACROS_SVH
`define ICACHE_REFILL_MACROS_SVH

// Width of one half line as it travels on the bus
`define ICACHE_BUNDLE_BITS 128

// Number of sets in the line store
`define ICACHE_SETS 16

// Fetch address width in bits
`define ICACHE_ADR_BITS 32

// Number of refill lines that may be in flight together
`define ICACHE_SLOTS 2

`endif

/* src/bus_pkg.sv */
// Bus transaction types
`default_nettype none

`include "icache_refill_macros.svh"

package bus_pkg;

	// Index of a refill slot
	typedef logic [$clog2(`ICACHE_SLOTS)-1:0] slot_t;

	// Transaction id carried by each request and echoed by its response
	// The sequence bit flips on every miss accepted into the slot,
	// so two ids issued back to back never compare equal
	typedef struct packed {
		logic  seq;
		slot_t slot;
		logic  half;
	} tid_t;

	// One response data word, a half line
	typedef logic [`ICACHE_BUNDLE_BITS-1:0] bus_data_t;

endpackage

`default_nettype wire

/* src/icache_pkg.sv */
// Instruction cache line types
`default_nettype none

`include "icache_refill_macros.svh"

package icache_pkg;

	// Byte offset bits inside a 32-byte line
	localparam int OFFSET_BITS = 5;
	localparam int SET_BITS = $clog2(`ICACHE_SETS);

	// Line address, the fetch address with the offset bits cleared
	typedef logic [`ICACHE_ADR_BITS-1:0] tag_t;

	// Set index, taken from the address just above the line offset
	typedef logic [SET_BITS-1:0] set_t;

	// A full line as it is handed to the store
	// Half 0 lives in the lower data bits
	typedef struct packed {
		logic [1:0]                      v;
		tag_t                            tag;
		logic [2*`ICACHE_BUNDLE_BITS-1:0] data;
	} line_t;

endpackage

`default_nettype wire

/* src/lfsr17.sv */
// Way replacement LFSR
`timescale 1ns/1ps
`default_nettype none

module lfsr17 (
	input  wire logic        clk,
	input  wire logic        rst,
	output logic      [16:0] o
);

	// Nonzero start value, the all-zero state would lock the register
	localparam logic [16:0] SEED = 17'h0ACE1;

	// ==================================================================
	// Fibonacci register for x^17 + x^14 + 1
	// ==================================================================

	// Steps on every clock so the way choice drifts with time
	// The feedback of taps 17 and 14 gives the full 2^17-1 period
	always_ff @(posedge clk) begin
		if (rst) begin
			o <= SEED;
		end else begin
			o <= {o[15:0], o[16] ^ o[13]};
		end
	end

endmodule

`default_nettype wire

/* src/icache_miss_issuer.sv */
// Refill slot allocation and request issue
`timescale 1ns/1ps
`default_nettype none

`include "icache_refill_macros.svh"

module icache_miss_issuer (
	input  wire logic                                 clk,
	input  wire logic                                 rst,
	input  wire logic                                 miss,
	input  wire icache_pkg::tag_t                     miss_adr,
	input  wire logic                                 done,
	input  wire bus_pkg::slot_t                       done_slot,
	output logic                                      miss_ready,
	output logic                                      req,
	output icache_pkg::tag_t                          req_adr,
	output bus_pkg::tid_t                             req_tid,
	output icache_pkg::tag_t [`ICACHE_SLOTS-1:0]      slot_tags
);

	// Byte address step between the two halves of a line
	localparam int HALF_SHIFT = $clog2(`ICACHE_BUNDLE_BITS / 8);
	localparam icache_pkg::tag_t OFFSET_MASK = (1 << icache_pkg::OFFSET_BITS) - 1;

	logic [`ICACHE_SLOTS-1:0] busy;
	logic [`ICACHE_SLOTS-1:0] seq;
	// Issue phase, 0 idle, 1 sends half 0, 2 sends half 1
	logic [1:0]               phase;
	bus_pkg::slot_t           iss_slot;
	bus_pkg::slot_t           free_slot;
	logic                     any_free;
	logic                     accept;

	// Lowest free slot wins, so scan from the top down
	always_comb begin
		free_slot = '0;
		any_free = 1'b0;
		for (int n = `ICACHE_SLOTS - 1; n >= 0; n--) begin
			if (!busy[n]) begin
				free_slot = bus_pkg::slot_t'(n);
				any_free = 1'b1;
			end
		end
	end

	// No new miss while the two requests of the last one are going out
	assign miss_ready = any_free && (phase == 2'd0);
	assign accept = miss && miss_ready;

	// ==================================================================
	// Request outputs
	// ==================================================================

	assign req = (phase != 2'd0);
	// phase[1] is set only in the second issue cycle, which carries half 1
	assign req_adr = slot_tags[iss_slot] | (icache_pkg::tag_t'(phase[1]) << HALF_SHIFT);
	assign req_tid = bus_pkg::tid_t'({seq[iss_slot], iss_slot, phase[1]});

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
			seq <= '0;
			phase <= 2'd0;
			iss_slot <= '0;
		end else begin
			// The ack processor returns the slot once its line is written
			if (done)
				busy[done_slot] <= 1'b0;
			if (accept) begin
				busy[free_slot] <= 1'b1;
				seq[free_slot] <= ~seq[free_slot];
				iss_slot <= free_slot;
				phase <= 2'd1;
			end else if (phase == 2'd1) begin
				phase <= 2'd2;
			end else begin
				phase <= 2'd0;
			end
		end
	end

	// Tag table, held for the ack processor while the slot is busy
	always_ff @(posedge clk) begin
		if (accept)
			slot_tags[free_slot] <= miss_adr & ~OFFSET_MASK;
	end

endmodule

`default_nettype wire

/* src/icache_ack_processor.sv */
// Refill response assembly
`timescale 1ns/1ps
`default_nettype none

`include "icache_refill_macros.svh"

module icache_ack_processor #(
	parameter int LOG_WAYS = 2
) (
	input  wire logic                                    clk,
	input  wire logic                                    rst,
	input  wire logic                                    ack,
	input  wire logic                                    ack_irq,
	input  wire bus_pkg::tid_t                           ack_tid,
	input  wire bus_pkg::bus_data_t                      ack_dat,
	input  wire icache_pkg::tag_t [`ICACHE_SLOTS-1:0]    slot_tags,
	input  wire logic [16:0]                             lfsr_o,
	output logic                                         wr_ic,
	output icache_pkg::line_t                            line,
	output logic [(LOG_WAYS > 0 ? LOG_WAYS : 1)-1:0]     way,
	output logic                                         done,
	output bus_pkg::slot_t                               done_slot
);

	localparam int WAY_W = (LOG_WAYS > 0) ? LOG_WAYS : 1;
	// A 1-way build masks the LFSR down to way 0
	localparam logic [WAY_W-1:0] WAY_MASK = WAY_W'((1 << LOG_WAYS) - 1);
	localparam int BB = `ICACHE_BUNDLE_BITS;

	bus_pkg::tid_t    last_tid;
	logic [1:0]       v [`ICACHE_SLOTS];
	logic [2*BB-1:0]  buf_data [`ICACHE_SLOTS];
	logic             counted;
	bus_pkg::slot_t   sel;
	logic             sel_ok;

	// ==================================================================
	// Response filter
	// ==================================================================

	// Interrupt responses are dropped here
	// A repeat of the last counted id is a duplicate and is ignored too
	assign counted = ack && !ack_irq && (ack_tid != last_tid);

	// Pick the lowest complete slot, a second one waits a cycle
	always_comb begin
		sel = '0;
		sel_ok = 1'b0;
		for (int n = `ICACHE_SLOTS - 1; n >= 0; n--) begin
			if (v[n] == 2'b11) begin
				sel = bus_pkg::slot_t'(n);
				sel_ok = 1'b1;
			end
		end
	end

	// ==================================================================
	// Line hand-off
	// ==================================================================

	assign wr_ic = sel_ok;
	assign done = sel_ok;
	assign done_slot = sel;
	// Low LFSR bits pick the victim way
	assign way = lfsr_o[WAY_W-1:0] & WAY_MASK;

	// The tag comes from the issuer's table, still held while the slot is busy
	always_comb begin
		line.v = v[sel];
		line.tag = slot_tags[sel];
		line.data = buf_data[sel];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			last_tid <= '0;
			for (int n = 0; n < `ICACHE_SLOTS; n++)
				v[n] <= 2'b00;
		end else begin
			// Valid bits drop in the same cycle the line goes out
			if (sel_ok)
				v[sel] <= 2'b00;
			if (counted) begin
				last_tid <= ack_tid;
				v[ack_tid.slot][ack_tid.half] <= 1'b1;
			end
		end
	end

	// Half data, placed by the half bit of the id
	always_ff @(posedge clk) begin
		if (counted) begin
			if (ack_tid.half)
				buf_data[ack_tid.slot][2*BB-1:BB] <= ack_dat;
			else
				buf_data[ack_tid.slot][BB-1:0] <= ack_dat;
		end
	end

endmodule

`default_nettype wire

/* src/icache_line_store.sv */
// Set-associative line store
`timescale 1ns/1ps
`default_nettype none

`include "icache_refill_macros.svh"

module icache_line_store #(
	parameter int LOG_WAYS = 2
) (
	input  wire logic                                clk,
	input  wire logic                                rst,
	input  wire logic                                wr_ic,
	input  wire icache_pkg::line_t                   line,
	input  wire logic [(LOG_WAYS > 0 ? LOG_WAYS : 1)-1:0] way,
	input  wire logic                                lookup,
	input  wire icache_pkg::tag_t                    lookup_adr,
	output logic                                     hit,
	output logic [2*`ICACHE_BUNDLE_BITS-1:0]         hit_data
);

	localparam int WAYS = 1 << LOG_WAYS;
	localparam icache_pkg::tag_t OFFSET_MASK = (1 << icache_pkg::OFFSET_BITS) - 1;

	logic [`ICACHE_SETS-1:0]           valid [WAYS];
	icache_pkg::tag_t                  tag_arr [WAYS][`ICACHE_SETS];
	logic [2*`ICACHE_BUNDLE_BITS-1:0]  data_arr [WAYS][`ICACHE_SETS];
	icache_pkg::set_t                  wr_set;
	icache_pkg::set_t                  rd_set;
	icache_pkg::tag_t                  rd_tag;
	logic                              match;
	logic [2*`ICACHE_BUNDLE_BITS-1:0]  match_data;

	assign wr_set = line.tag[icache_pkg::OFFSET_BITS +: icache_pkg::SET_BITS];
	assign rd_set = lookup_adr[icache_pkg::OFFSET_BITS +: icache_pkg::SET_BITS];
	assign rd_tag = lookup_adr & ~OFFSET_MASK;

	// Compare every way of the addressed set, at most one can match
	always_comb begin
		match = 1'b0;
		match_data = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid[w][rd_set] && tag_arr[w][rd_set] == rd_tag) begin
				match = 1'b1;
				match_data = data_arr[w][rd_set];
			end
		end
	end

	// ==================================================================
	// Write port and registered lookup
	// ==================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++)
				valid[w] <= '0;
			hit <= 1'b0;
			hit_data <= '0;
		end else begin
			if (wr_ic)
				valid[way][wr_set] <= &line.v;
			// Result reflects the arrays before this edge's write
			hit <= lookup && match;
			hit_data <= (lookup && match) ? match_data : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ic) begin
			tag_arr[way][wr_set] <= line.tag;
			data_arr[way][wr_set] <= line.data;
		end
	end

endmodule

`default_nettype wire

/* src/icache_refill_top.sv */
// Instruction cache refill top level
`timescale 1ns/1ps
`default_nettype none

`include "icache_refill_macros.svh"

module icache_refill_top #(
	parameter int LOG_WAYS = 2
) (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire logic                         miss,
	input  wire icache_pkg::tag_t             miss_adr,
	output logic                              miss_ready,
	output logic                              req,
	output icache_pkg::tag_t                  req_adr,
	output bus_pkg::tid_t                     req_tid,
	input  wire logic                         ack,
	input  wire logic                         ack_irq,
	input  wire bus_pkg::tid_t                ack_tid,
	input  wire bus_pkg::bus_data_t           ack_dat,
	input  wire logic                         lookup,
	input  wire icache_pkg::tag_t             lookup_adr,
	output logic                              hit,
	output logic [2*`ICACHE_BUNDLE_BITS-1:0]  hit_data
);

	// Slot tag table shared from the issuer to the ack processor
	icache_pkg::tag_t [`ICACHE_SLOTS-1:0]   slot_tags;
	logic                                   done;
	bus_pkg::slot_t                         done_slot;
	logic                                   wr_ic;
	icache_pkg::line_t                      line;
	logic [(LOG_WAYS > 0 ? LOG_WAYS : 1)-1:0] way;
	logic [16:0]                            lfsr_o;

	lfsr17 u_lfsr (.clk(clk), .rst(rst), .o(lfsr_o));

	icache_miss_issuer u_issuer (
		.clk(clk), .rst(rst), .miss(miss), .miss_adr(miss_adr),
		.done(done), .done_slot(done_slot), .miss_ready(miss_ready),
		.req(req), .req_adr(req_adr), .req_tid(req_tid), .slot_tags(slot_tags)
	);

	icache_ack_processor #(.LOG_WAYS(LOG_WAYS)) u_ack (
		.clk(clk), .rst(rst), .ack(ack), .ack_irq(ack_irq), .ack_tid(ack_tid),
		.ack_dat(ack_dat), .slot_tags(slot_tags), .lfsr_o(lfsr_o), .wr_ic(wr_ic),
		.line(line), .way(way), .done(done), .done_slot(done_slot)
	);

	icache_line_store #(.LOG_WAYS(LOG_WAYS)) u_store (
		.clk(clk), .rst(rst), .wr_ic(wr_ic), .line(line), .way(way),
		.lookup(lookup), .lookup_adr(lookup_adr), .hit(hit), .hit_data(hit_data)
	);

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD_NS = 50,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst
);

	// Free-running clock of period 100 ns
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// Reset is held for the first two rising edges
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* dv/icache_refill_asserts.sv */
// Refill protocol assertions
`timescale 1ns/1ps
`default_nettype none

module icache_refill_asserts (
	input wire logic           clk,
	input wire logic           rst,
	input wire logic           miss,
	input wire logic           req,
	input wire logic           miss_ready,
	input wire logic           wr_ic,
	input wire logic           done,
	input wire bus_pkg::slot_t done_slot
);

	// Failures seen so far, read by the testbench at the end of the run
	int unsigned fail_count = 0;

	// ==================================================================
	// Request issue
	// ==================================================================

	// A line is asked for in exactly two request cycles
	req_max_two: assert property (@(posedge clk) disable iff (rst)
		($past(req, 2) && $past(req)) |-> !req)
	else begin
		fail_count = fail_count + 1;
		$error("req stayed high for three cycles in a row");
	end

	// Both cycles after a taken miss carry a request and refuse the next miss
	ready_low_in_issue: assert property (@(posedge clk) disable iff (rst)
		($past(miss && miss_ready) || $past(miss && miss_ready, 2)) |-> (req && !miss_ready))
	else begin
		fail_count = fail_count + 1;
		$error("miss_ready was high or req low in the two cycles after a miss was taken");
	end

	// ==================================================================
	// Line hand-off
	// ==================================================================

	// Writing a line and freeing its slot happen in the same cycle
	// A slot hands its line over once, its valid bits drop with the write
	wr_with_done: assert property (@(posedge clk) disable iff (rst)
		wr_ic |-> (done && !($past(wr_ic) && $past(done_slot) == done_slot)))
	else begin
		fail_count = fail_count + 1;
		$error("wr_ic was pulsed without done, or the same slot was written twice in a row");
	end

endmodule

bind icache_refill_top icache_refill_asserts u_asserts (
	.clk(clk), .rst(rst), .miss(miss), .req(req), .miss_ready(miss_ready),
	.wr_ic(wr_ic), .done(done), .done_slot(done_slot)
);

`default_nettype wire

/* dv/icache_refill_tb.sv */
// Instruction cache refill testbench
`timescale 1ns/1ps
`default_nettype none

`include "icache_refill_macros.svh"

module icache_refill_tb;

	localparam logic [31:0] SEED = 32'h510a_9a40;
	// Six short tests need a few hundred cycles, so this leaves ample margin
	localparam logic [31:0] CYCLE_LIMIT = 32'd4000;
	// A line is 32 bytes, a half line 16 bytes
	localparam icache_pkg::tag_t LINE_MASK = 32'h0000_001F;
	localparam icache_pkg::tag_t HALF_STEP = 32'h0000_0010;
	localparam int LINE_BITS = 2 * `ICACHE_BUNDLE_BITS;

	typedef struct packed {
		icache_pkg::tag_t adr;
		bus_pkg::tid_t    tid;
		logic [31:0]      due;
	} pend_t;

	typedef struct packed {
		logic               irq;
		bus_pkg::tid_t      tid;
		bus_pkg::bus_data_t dat;
	} inj_t;

	logic                   clk;
	logic                   rst;
	logic                   miss = 1'b0;
	icache_pkg::tag_t       miss_adr = '0;
	logic                   miss_ready;
	logic                   req;
	icache_pkg::tag_t       req_adr;
	bus_pkg::tid_t          req_tid;
	logic                   ack = 1'b0;
	logic                   ack_irq = 1'b0;
	bus_pkg::tid_t          ack_tid = '0;
	bus_pkg::bus_data_t     ack_dat = '0;
	logic                   lookup = 1'b0;
	icache_pkg::tag_t       lookup_adr = '0;
	logic                   hit;
	logic [LINE_BITS-1:0]   hit_data;

	logic [31:0]            rng = SEED;
	logic [31:0]            cycle = '0;
	logic                   hold = 1'b0;
	logic [31:0]            done_count = '0;
	logic [31:0]            done_before;
	icache_pkg::tag_t       last_adr;
	pend_t                  pend_q [$];
	inj_t                   inj_q [$];
	icache_pkg::tag_t       written_tags [$];
	string                  test_name;
	int                     errors = 0;
	int                     errors_at_start;
	int                     tests_run = 0;
	int                     tests_ok = 0;

	tb_clock u_clock (.clk(clk), .rst(rst));

	icache_refill_top i_dut (
		.clk(clk), .rst(rst), .miss(miss), .miss_adr(miss_adr), .miss_ready(miss_ready),
		.req(req), .req_adr(req_adr), .req_tid(req_tid), .ack(ack), .ack_irq(ack_irq),
		.ack_tid(ack_tid), .ack_dat(ack_dat), .lookup(lookup), .lookup_adr(lookup_adr),
		.hit(hit), .hit_data(hit_data)
	);

	// ==================================================================
	// Random numbers and expected data
	// ==================================================================

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Upper bits only, the low bits of an LCG repeat quickly
	function logic [31:0] next_rand();
		rng = lcg(rng);
		return rng >> 16;
	endfunction

	// Half-line contents hashed from the whole byte address
	function automatic bus_pkg::bus_data_t half_data(input icache_pkg::tag_t adr);
		logic [31:0]        s;
		bus_pkg::bus_data_t d;
		s = adr ^ SEED;
		for (int k = 0; k < `ICACHE_BUNDLE_BITS / 32; k++) begin
			s = lcg(s);
			d[32*k +: 32] = s;
		end
		return d;
	endfunction

	function automatic logic [LINE_BITS-1:0] line_data(input icache_pkg::tag_t adr);
		icache_pkg::tag_t base;
		base = adr & ~LINE_MASK;
		return {half_data(base | HALF_STEP), half_data(base)};
	endfunction

	// ==================================================================
	// Bus memory model
	// ==================================================================

	// Requests wait a random delay, then one ready answer is picked at random,
	// which reorders and interleaves answers of lines in flight
	always @(posedge clk) begin : bus_model
		int    ready_idx [$];
		int    sel;
		pend_t p;
		inj_t  j;
		ack <= 1'b0;
		ack_irq <= 1'b0;
		if (!rst) begin
			if (req) begin
				p.adr = req_adr;
				p.tid = req_tid;
				p.due = cycle + 32'd1 + (next_rand() % 32'd7);
				pend_q.push_back(p);
			end
			// Responses forced by a test go out first
			if (inj_q.size() > 0) begin
				j = inj_q.pop_front();
				ack <= 1'b1;
				ack_irq <= j.irq;
				ack_tid <= j.tid;
				ack_dat <= j.dat;
			end else if (!hold) begin
				ready_idx.delete();
				foreach (pend_q[n])
					if (pend_q[n].due <= cycle)
						ready_idx.push_back(n);
				if (ready_idx.size() > 0) begin
					sel = ready_idx[next_rand() % ready_idx.size()];
					p = pend_q[sel];
					pend_q.delete(sel);
					ack <= 1'b1;
					ack_tid <= p.tid;
					ack_dat <= half_data(p.adr);
				end
			end
		end
	end

	// Lines handed to the store and slots freed, seen from inside the DUT
	always @(posedge clk) begin
		if (!rst && i_dut.wr_ic)
			written_tags.push_back(i_dut.line.tag);
		if (!rst && i_dut.done)
			done_count <= done_count + 32'd1;
	end

	// Watchdog
	always @(posedge clk) begin
		cycle <= cycle + 32'd1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Run stopped: the cycle limit of %0d was reached", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// ==================================================================
	// Stimulus tasks
	// ==================================================================

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == errors_at_start) begin
			tests_ok++;
			$display("test %s ok", test_name);
		end else begin
			$display("test %s failed with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	// Holds miss until the edge where miss_ready takes it
	task automatic issue_miss(input icache_pkg::tag_t adr);
		@(posedge clk);
		miss <= 1'b1;
		miss_adr <= adr;
		do @(posedge clk); while (!miss_ready);
		miss <= 1'b0;
	endtask

	task automatic wait_written(input icache_pkg::tag_t adr);
		logic found;
		found = 1'b0;
		while (!found) begin
			@(posedge clk);
			foreach (written_tags[n])
				if (written_tags[n] == (adr & ~LINE_MASK))
					found = 1'b1;
		end
	endtask

	// The result is registered, so it is read one cycle after the lookup
	task automatic check_lookup(input icache_pkg::tag_t adr, input logic exp_hit,
			input logic [LINE_BITS-1:0] exp_data);
		@(posedge clk);
		lookup <= 1'b1;
		lookup_adr <= adr;
		@(posedge clk);
		lookup <= 1'b0;
		@(posedge clk);
		assert (hit === exp_hit && hit_data === exp_data) else begin
			errors++;
			$display("ERROR %s: expected hit %0b data %h, actual hit %0b data %h",
				test_name, exp_hit, exp_data, hit, hit_data);
		end
	endtask

	// ==================================================================
	// Tests
	// ==================================================================

	initial begin
		do @(posedge clk); while (rst);

		start_test("single_miss");
		issue_miss(32'h0000_1047);
		wait_written(32'h0000_1040);
		check_lookup(32'h0000_1040, 1'b1, line_data(32'h0000_1040));
		finish_test();

		// Both lines queue up first, then their answers come back mixed
		start_test("two_lines");
		hold <= 1'b1;
		issue_miss(32'h0000_2060);
		issue_miss(32'h0000_30A0);
		while (pend_q.size() < 4) @(posedge clk);
		hold <= 1'b0;
		wait_written(32'h0000_2060);
		wait_written(32'h0000_30A0);
		check_lookup(32'h0000_2060, 1'b1, line_data(32'h0000_2060));
		check_lookup(32'h0000_30A0, 1'b1, line_data(32'h0000_30A0));
		finish_test();

		// Half 0 arrives between an interrupt answer and a repeat of its own id
		start_test("filtered_acks");
		hold <= 1'b1;
		issue_miss(32'h0000_40C0);
		while (pend_q.size() < 2) @(posedge clk);
		inj_q.push_back({1'b1, pend_q[1].tid, ~half_data(32'h0000_40D0)});
		inj_q.push_back({1'b0, pend_q[0].tid, half_data(32'h0000_40C0)});
		inj_q.push_back({1'b0, pend_q[0].tid, ~half_data(32'h0000_40C0)});
		pend_q.delete(0);
		while (inj_q.size() > 0) @(posedge clk);
		check_lookup(32'h0000_40C0, 1'b0, '0);
		hold <= 1'b0;
		wait_written(32'h0000_40C0);
		check_lookup(32'h0000_40C0, 1'b1, line_data(32'h0000_40C0));
		finish_test();

		start_test("never_fetched");
		check_lookup(32'h0000_5000, 1'b0, '0);
		finish_test();

		// Two lines fill both slots, a third miss must wait for a done
		start_test("slots_full");
		hold <= 1'b1;
		issue_miss(32'h0000_6100);
		issue_miss(32'h0000_7120);
		@(posedge clk);
		miss <= 1'b1;
		miss_adr <= 32'h0000_8140;
		repeat (8) begin
			@(posedge clk);
			assert (!miss_ready) else begin
				errors++;
				$display("ERROR %s: expected miss_ready 0, actual %0b", test_name, miss_ready);
			end
		end
		done_before = done_count;
		hold <= 1'b0;
		do @(posedge clk); while (!miss_ready);
		miss <= 1'b0;
		assert (done_count > done_before) else begin
			errors++;
			$display("%s: the held miss was taken before any slot was freed", test_name);
		end
		wait_written(32'h0000_6100);
		wait_written(32'h0000_7120);
		wait_written(32'h0000_8140);
		check_lookup(32'h0000_8140, 1'b1, line_data(32'h0000_8140));
		finish_test();

		// Five lines share set 15, more than the store has ways
		start_test("one_set");
		for (int k = 0; k < 5; k++)
			issue_miss(32'h0001_01E0 + 32'h200 * k);
		for (int k = 0; k < 5; k++)
			wait_written(32'h0001_01E0 + 32'h200 * k);
		// Two lines are in flight, so the last one written need not be the last one asked for
		last_adr = '0;
		foreach (written_tags[n])
			for (int k = 0; k < 5; k++)
				if (written_tags[n] == 32'h0001_01E0 + 32'h200 * k)
					last_adr = written_tags[n];
		check_lookup(last_adr, 1'b1, line_data(last_adr));
		finish_test();

		repeat (4) @(posedge clk);
		$display("tests run %0d, passed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_ok, errors, i_dut.u_asserts.fail_count);
		if (errors == 0 && i_dut.u_asserts.fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/bus_pkg.sv
src/icache_pkg.sv
src/lfsr17.sv
src/icache_miss_issuer.sv
src/icache_ack_processor.sv
src/icache_line_store.sv
src/icache_refill_top.sv
dv/tb_clock.sv
dv/icache_refill_asserts.sv
dv/icache_refill_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := icache_refill_tb
FILELIST := sim.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
